// ==== sources.f ====
+incdir+include
rtl/periph_pkg.sv
rtl/bus_decoder.sv
rtl/mtimer.sv
rtl/ram_store.sv
rtl/periph_subsys.sv
verif/periph_subsys_checker.sv
verif/tb_periph_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

out="$(verilator --binary --timing --assert -f sources.f --top-module tb_periph_subsys \
  -Mdir obj_dir -o tb_sim 2>&1 && ./obj_dir/tb_sim +verilator+error+limit+100 2>&1)"
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1

// ==== verif/tb_periph_subsys.sv ====
// Testbench for the peripheral subsystem
// Clock, reset, LFSR stimulus, bus tasks, compare tasks and directed tests

`timescale 1ns/1ps

`include "periph_defs.svh"

module tb_periph_subsys import periph_pkg::*; ();

  localparam bus_addr_t TimerAddr = bus_addr_t'(`TIMER_BASE) << `DEV_ADDR_BITS;
  localparam bus_addr_t NoneAddr  = bus_addr_t'(2) << `DEV_ADDR_BITS;
  localparam bus_addr_t FarAddr   = 32'hDEAD_0000;
  localparam int        RspWait   = 8;
  localparam int        IntrWait  = 40;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        bus_req_i;
  bus_addr_t   bus_addr_i;
  logic        bus_we_i;
  bus_be_t     bus_be_i;
  bus_data_t   bus_wdata_i;
  logic        bus_rvalid_o;
  bus_data_t   bus_rdata_o;
  logic        bus_err_o;
  logic        timer_intr_o;
  logic [31:0] lfsr_q;
  int          edge_cnt = 0;
  int          last_edge;
  bus_data_t   ram_model [`RAM_WORDS];
  logic [7:0]  ram_idx [8];
  timer_cnt_t  cmp_model;
  timer_cnt_t  mtime_ref;
  int          mtime_ref_edge;

  periph_subsys i_periph_subsys (.*);

  bind periph_subsys periph_subsys_checker i_periph_subsys_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus_req_i    (bus_req_i),
    .bus_addr_i   (bus_addr_i),
    .bus_we_i     (bus_we_i),
    .bus_rvalid_o (bus_rvalid_o),
    .timer_intr_o (timer_intr_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) edge_cnt <= edge_cnt + 1;

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step for each bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic bus_data_t lane_merge(bus_data_t old_w, bus_data_t new_w, bus_be_t be);
    bus_data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic bus_addr_t ram_addr(logic [7:0] idx);
    return {22'd0, idx, 2'b00};
  endfunction

  // Value a read of mtime captures at a given request edge
  function automatic timer_cnt_t mtime_at(int req_edge);
    return mtime_ref + timer_cnt_t'(req_edge - mtime_ref_edge - 1);
  endfunction

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_cnt(input string name, input timer_cnt_t exp, input timer_cnt_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  // Called at a falling edge, returns at the falling edge of the response cycle
  task automatic bus_access(input bus_addr_t addr, input logic we, input bus_be_t be,
                            input bus_data_t wdata, output bus_data_t rdata, output logic err);
    int waited;
    bus_req_i   = 1'b1;
    bus_addr_i  = addr;
    bus_we_i    = we;
    bus_be_i    = be;
    bus_wdata_i = wdata;
    @(posedge clk_i);
    @(negedge clk_i);
    last_edge = edge_cnt;
    bus_req_i = 1'b0;
    waited    = 0;
    while (!bus_rvalid_o && waited < RspWait) begin
      @(negedge clk_i);
      waited++;
    end
    if (!bus_rvalid_o) begin
      $display("No response within %0d cycles to the request at %h", RspWait, addr);
      stop_on_error();
    end else if (waited != 0) begin
      $display("Response to the request at %h came %0d cycles late", addr, waited);
      stop_on_error();
    end
    rdata = bus_rdata_o;
    err   = bus_err_o;
  endtask

  task automatic do_write(input bus_addr_t addr, input bus_be_t be, input bus_data_t data,
                          input logic exp_err);
    bus_data_t rdata;
    logic      err;
    bus_access(addr, 1'b1, be, data, rdata, err);
    check_bit("bus_err_o", exp_err, err);
  endtask

  task automatic do_read(input bus_addr_t addr, input bus_data_t exp, input logic exp_err);
    bus_data_t rdata;
    logic      err;
    bus_access(addr, 1'b0, 4'hF, '0, rdata, err);
    check_bit("bus_err_o", exp_err, err);
    check_data("bus_rdata_o", exp, rdata);
  endtask

  task automatic cmp_write(input logic high, input bus_be_t be, input bus_data_t data);
    if (high) begin
      cmp_model[63:32] = lane_merge(cmp_model[63:32], data, be);
      do_write(TimerAddr + `MTIMECMP_HIGH, be, data, 1'b0);
    end else begin
      cmp_model[31:0] = lane_merge(cmp_model[31:0], data, be);
      do_write(TimerAddr + `MTIMECMP_LOW, be, data, 1'b0);
    end
  endtask

  task automatic mtime_read(input logic high, output bus_data_t val);
    logic       err;
    timer_cnt_t exp_t;
    bus_access(TimerAddr + (high ? `MTIME_HIGH : `MTIME_LOW), 1'b0, 4'hF, '0, val, err);
    exp_t = mtime_at(last_edge);
    check_bit("bus_err_o", 1'b0, err);
    check_data("bus_rdata_o", high ? exp_t[63:32] : exp_t[31:0], val);
  endtask

  task automatic test_reset();
    check_bit("bus_rvalid_o", 1'b0, bus_rvalid_o);
    check_bit("timer_intr_o", 1'b0, timer_intr_o);
    do_read(TimerAddr + `MTIMECMP_LOW, '0, 1'b0);
    do_read(TimerAddr + `MTIMECMP_HIGH, '0, 1'b0);
  endtask

  task automatic test_ram_bytes();
    logic [31:0] rnd;
    bus_data_t   data;
    // Full words first, so every byte of the model is known
    for (int i = 0; i < 8; i++) begin
      rnd = rand_bits(8);
      ram_idx[i] = rnd[7:0];
      data = rand_bits(32);
      ram_model[ram_idx[i]] = data;
      do_write(ram_addr(ram_idx[i]), 4'hF, data, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      rnd = rand_bits(4);
      data = rand_bits(32);
      ram_model[ram_idx[i]] = lane_merge(ram_model[ram_idx[i]], data, rnd[3:0]);
      do_write(ram_addr(ram_idx[i]), rnd[3:0], data, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      do_read(ram_addr(ram_idx[i]), ram_model[ram_idx[i]], 1'b0);
    end
  endtask

  task automatic test_timer_regs();
    logic [31:0] rnd;
    logic        err;
    bus_data_t   lo;
    bus_data_t   hi;
    timer_cnt_t  t_hi;
    timer_cnt_t  t_lo;
    int          w_edge;
    int          hi_edge;
    cmp_write(1'b0, 4'hF, rand_bits(32));
    cmp_write(1'b1, 4'hF, rand_bits(32));
    rnd = rand_bits(4);
    cmp_write(1'b1, rnd[3:0], rand_bits(32));
    rnd = rand_bits(4);
    cmp_write(1'b0, rnd[3:0], rand_bits(32));
    do_read(TimerAddr + `MTIMECMP_LOW, cmp_model[31:0], 1'b0);
    do_read(TimerAddr + `MTIMECMP_HIGH, cmp_model[63:32], 1'b0);
    // Low half starts close to wrapping and keeps counting while high is written
    do_write(TimerAddr + `MTIME_LOW, 4'hF, 32'hFFFF_FFF0, 1'b0);
    w_edge = last_edge;
    do_write(TimerAddr + `MTIME_HIGH, 4'hF, 32'h0000_0005, 1'b0);
    mtime_ref      = {32'h0000_0005, 32'hFFFF_FFF0 + 32'(last_edge - w_edge)};
    mtime_ref_edge = last_edge;
    mtime_read(1'b0, lo);
    repeat (20) @(negedge clk_i);
    // Both halves after the low word has carried into the high word
    bus_access(TimerAddr + `MTIME_HIGH, 1'b0, 4'hF, '0, hi, err);
    check_bit("bus_err_o", 1'b0, err);
    hi_edge = last_edge;
    bus_access(TimerAddr + `MTIME_LOW, 1'b0, 4'hF, '0, lo, err);
    check_bit("bus_err_o", 1'b0, err);
    t_hi = mtime_at(hi_edge);
    t_lo = mtime_at(last_edge);
    check_cnt("mtime", {t_hi[63:32], t_lo[31:0]}, {hi, lo});
  endtask

  task automatic test_errors();
    bus_data_t rdata;
    logic      err;
    do_read(NoneAddr, '0, 1'b1);
    do_read(FarAddr, '0, 1'b1);
    bus_access(TimerAddr + 32'h10, 1'b0, 4'hF, '0, rdata, err);
    check_bit("bus_err_o", 1'b1, err);
    bus_access(TimerAddr + 32'h3FC, 1'b1, 4'hF, 32'h1234_5678, rdata, err);
    check_bit("bus_err_o", 1'b1, err);
    // Same low address bits as a RAM word and as mtimecmp
    do_write(NoneAddr + ram_addr(ram_idx[0]), 4'hF, 32'h5A5A_5A5A, 1'b1);
    do_write(NoneAddr + `MTIMECMP_LOW, 4'hF, 32'hA5A5_A5A5, 1'b1);
    do_read(ram_addr(ram_idx[0]), ram_model[ram_idx[0]], 1'b0);
    do_read(TimerAddr + `MTIMECMP_LOW, cmp_model[31:0], 1'b0);
  endtask

  task automatic test_interrupt();
    bus_data_t  lo;
    timer_cnt_t target;
    int         rise_edge;
    int         waited;
    cmp_write(1'b1, 4'hF, 32'hFFFF_FFFF);
    mtime_read(1'b0, lo);
    target    = mtime_at(last_edge) + 64'd20;
    rise_edge = last_edge + 20;
    cmp_write(1'b0, 4'hF, target[31:0]);
    cmp_write(1'b1, 4'hF, target[63:32]);
    // Low until mtime has reached the compare value
    while (edge_cnt < rise_edge) begin
      check_bit("timer_intr_o", 1'b0, timer_intr_o);
      @(negedge clk_i);
    end
    waited = 0;
    while (!timer_intr_o && waited < IntrWait) begin
      @(negedge clk_i);
      waited++;
    end
    if (!timer_intr_o) begin
      $display("timer_intr_o did not rise within %0d cycles", IntrWait);
      stop_on_error();
    end
    repeat (5) begin
      @(negedge clk_i);
      check_bit("timer_intr_o", 1'b1, timer_intr_o);
    end
    cmp_write(1'b1, 4'hF, 32'hFFFF_0000);
    waited = 0;
    while (timer_intr_o && waited < IntrWait) begin
      @(negedge clk_i);
      waited++;
    end
    if (timer_intr_o) begin
      $display("timer_intr_o did not fall after the mtimecmp write");
      stop_on_error();
    end
    repeat (3) @(negedge clk_i);
    check_bit("timer_intr_o", 1'b0, timer_intr_o);
  endtask

  // Every call issues on the edge right after the previous one
  task automatic test_back_to_back();
    bus_data_t data;
    bus_data_t val;
    data = rand_bits(32);
    do_read(ram_addr(ram_idx[1]), ram_model[ram_idx[1]], 1'b0);
    do_read(TimerAddr + `MTIMECMP_LOW, cmp_model[31:0], 1'b0);
    do_read(NoneAddr, '0, 1'b1);
    ram_model[ram_idx[2]] = data;
    do_write(ram_addr(ram_idx[2]), 4'hF, data, 1'b0);
    do_read(TimerAddr + `MTIMECMP_HIGH, cmp_model[63:32], 1'b0);
    do_write(FarAddr, 4'hF, ~data, 1'b1);
    do_read(ram_addr(ram_idx[2]), ram_model[ram_idx[2]], 1'b0);
    mtime_read(1'b0, val);
  endtask

  initial begin
    lfsr_q         = 32'ha0d7;
    rst_ni         = 1'b0;
    bus_req_i      = 1'b0;
    bus_addr_i     = '0;
    bus_we_i       = 1'b0;
    bus_be_i       = '0;
    bus_wdata_i    = '0;
    cmp_model      = '0;
    mtime_ref      = '0;
    mtime_ref_edge = 0;
    last_edge      = 0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset();
    test_ram_bytes();
    test_timer_regs();
    test_errors();
    test_interrupt();
    test_back_to_back();
    repeat (2) @(negedge clk_i);
    if (i_periph_subsys.i_periph_subsys_checker.fail_cnt == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Assertion failures: %0d", i_periph_subsys.i_periph_subsys_checker.fail_cnt);
      stop_on_error();
    end
  end

endmodule

// ==== verif/periph_subsys_checker.sv ====
// Bound assertions for the peripheral subsystem
// Response timing, rvalid in reset and interrupt stability

`timescale 1ns/1ps

`include "periph_defs.svh"

module periph_subsys_checker import periph_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input logic      bus_req_i,
  input bus_addr_t bus_addr_i,
  input logic      bus_we_i,
  input logic      bus_rvalid_o,
  input logic      timer_intr_o
);

  localparam int unsigned RegionW = `BUS_AW - `DEV_ADDR_BITS;

  logic [RegionW-1:0]        region;
  logic [`DEV_ADDR_BITS-1:0] offset;
  logic                      cmp_write;
  int unsigned               fail_cnt = 0;

  assign region = bus_addr_i[`BUS_AW-1:`DEV_ADDR_BITS];
  assign offset = bus_addr_i[`DEV_ADDR_BITS-1:0];

  // Write that reaches either mtimecmp half
  assign cmp_write = bus_req_i && bus_we_i && (region == RegionW'(`TIMER_BASE)) &&
                     ((offset == `DEV_ADDR_BITS'(`MTIMECMP_LOW)) ||
                      (offset == `DEV_ADDR_BITS'(`MTIMECMP_HIGH)));

  // Exactly one cycle from request to response
  a_rsp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i |=> bus_rvalid_o)
    else begin
      fail_cnt++;
      $error("bus_rvalid_o missing one cycle after a request");
    end

  a_no_rsp_without_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !bus_req_i |=> !bus_rvalid_o)
    else begin
      fail_cnt++;
      $error("bus_rvalid_o high without a request one cycle before");
    end

  a_rvalid_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !bus_rvalid_o)
    else begin
      fail_cnt++;
      $error("bus_rvalid_o high during reset");
    end

  // Sticky interrupt, only an mtimecmp write clears it
  a_intr_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(timer_intr_o) |-> $past(cmp_write))
    else begin
      fail_cnt++;
      $error("timer_intr_o fell without an mtimecmp write");
    end

endmodule

// ==== rtl/periph_subsys.sv ====
// Peripheral subsystem top level
// Bus decoder with a word RAM and the machine timer behind it

`timescale 1ns/1ps

module periph_subsys import periph_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Bus from the master
  input  logic      bus_req_i,
  input  bus_addr_t bus_addr_i,
  input  logic      bus_we_i,
  input  bus_be_t   bus_be_i,
  input  bus_data_t bus_wdata_i,
  output logic      bus_rvalid_o,
  output bus_data_t bus_rdata_o,
  output logic      bus_err_o,
  // Timer interrupt
  output logic      timer_intr_o
);

  logic      ram_req;
  logic      timer_req;
  bus_data_t ram_rdata;
  logic      timer_rvalid;
  bus_data_t timer_rdata;
  logic      timer_err;

  bus_decoder i_bus_decoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .bus_req_i      (bus_req_i),
    .bus_addr_i     (bus_addr_i),
    .ram_rdata_i    (ram_rdata),
    .timer_rvalid_i (timer_rvalid),
    .timer_rdata_i  (timer_rdata),
    .timer_err_i    (timer_err),
    .ram_req_o      (ram_req),
    .timer_req_o    (timer_req),
    .bus_rvalid_o   (bus_rvalid_o),
    .bus_rdata_o    (bus_rdata_o),
    .bus_err_o      (bus_err_o)
  );

  // Address, write enable and data go to both devices unchanged
  ram_store i_ram_store (
    .clk_i       (clk_i),
    .ram_req_i   (ram_req),
    .ram_addr_i  (bus_addr_i),
    .ram_we_i    (bus_we_i),
    .ram_be_i    (bus_be_i),
    .ram_wdata_i (bus_wdata_i),
    .ram_rdata_o (ram_rdata)
  );

  mtimer i_mtimer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .timer_req_i    (timer_req),
    .timer_addr_i   (bus_addr_i),
    .timer_we_i     (bus_we_i),
    .timer_be_i     (bus_be_i),
    .timer_wdata_i  (bus_wdata_i),
    .timer_rvalid_o (timer_rvalid),
    .timer_rdata_o  (timer_rdata),
    .timer_err_o    (timer_err),
    .timer_intr_o   (timer_intr_o)
  );

endmodule

// ==== rtl/ram_store.sv ====
// Word RAM for the peripheral bus
// Byte-enabled writes and registered read data

`timescale 1ns/1ps

`include "periph_defs.svh"

module ram_store import periph_pkg::*; (
  input  logic      clk_i,
  // Bus interface
  input  logic      ram_req_i,
  input  bus_addr_t ram_addr_i,
  input  logic      ram_we_i,
  input  bus_be_t   ram_be_i,
  input  bus_data_t ram_wdata_i,
  output bus_data_t ram_rdata_o
);

  localparam int unsigned IdxW = $clog2(`RAM_WORDS);

  bus_data_t       mem [`RAM_WORDS];
  logic [IdxW-1:0] word_idx;
  bus_data_t       rdata_q;

  // Word index, byte offset bits dropped
  assign word_idx = ram_addr_i[IdxW+1:2];

  // Per-lane write
  always_ff @(posedge clk_i) begin
    if (ram_req_i && ram_we_i) begin
      for (int b = 0; b < `BUS_DW / 8; b++) begin
        if (ram_be_i[b]) begin
          mem[word_idx][b*8+:8] <= ram_wdata_i[b*8+:8];
        end
      end
    end
  end

  // Read port, data valid in the following cycle
  always_ff @(posedge clk_i) begin
    if (ram_req_i && !ram_we_i) begin
      rdata_q <= mem[word_idx];
    end
  end

  assign ram_rdata_o = rdata_q;

endmodule

// ==== rtl/mtimer.sv ====
// Machine timer with 64-bit mtime and mtimecmp
// Byte-enabled register writes, registered reads and a sticky compare interrupt

`timescale 1ns/1ps

`include "periph_defs.svh"

module mtimer import periph_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Bus interface
  input  logic      timer_req_i,
  input  bus_addr_t timer_addr_i,
  input  logic      timer_we_i,
  input  bus_be_t   timer_be_i,
  input  bus_data_t timer_wdata_i,
  output logic      timer_rvalid_o,
  output bus_data_t timer_rdata_o,
  output logic      timer_err_o,
  // Compare interrupt, level
  output logic      timer_intr_o
);

  // Replace the enabled byte lanes of a word
  function automatic bus_data_t merge_bytes(bus_data_t old_w, bus_data_t new_w, bus_be_t be);
    bus_data_t res;
    res = old_w;
    for (int b = 0; b < `BUS_DW / 8; b++) begin
      if (be[b]) begin
        res[b*8+:8] = new_w[b*8+:8];
      end
    end
    return res;
  endfunction

  logic [`DEV_ADDR_BITS-1:0] reg_off;
  logic                      wr_en;
  logic                      mtime_we;
  logic                      mtimeh_we;
  logic                      mtimecmp_we;
  logic                      mtimecmph_we;
  logic                      cmp_wr;
  timer_cnt_t                mtime_q;
  timer_cnt_t                mtime_d;
  timer_cnt_t                mtime_inc;
  timer_cnt_t                mtimecmp_q;
  timer_cnt_t                mtimecmp_d;
  logic                      armed_q;
  logic                      intr_q;
  logic                      intr_d;
  bus_data_t                 rdata_d;
  bus_data_t                 rdata_q;
  logic                      err_d;
  logic                      err_q;
  logic                      rvalid_q;

  assign reg_off = timer_addr_i[`DEV_ADDR_BITS-1:0];
  assign wr_en   = timer_req_i & timer_we_i;

  // Register write enables
  assign mtime_we     = wr_en & (reg_off == `DEV_ADDR_BITS'(`MTIME_LOW));
  assign mtimeh_we    = wr_en & (reg_off == `DEV_ADDR_BITS'(`MTIME_HIGH));
  assign mtimecmp_we  = wr_en & (reg_off == `DEV_ADDR_BITS'(`MTIMECMP_LOW));
  assign mtimecmph_we = wr_en & (reg_off == `DEV_ADDR_BITS'(`MTIMECMP_HIGH));
  assign cmp_wr       = mtimecmp_we | mtimecmph_we;

  // Free-running count, a written half overrides the increment
  assign mtime_inc = mtime_q + 64'd1;

  assign mtime_d = {
    mtimeh_we ? merge_bytes(mtime_q[63:32], timer_wdata_i, timer_be_i) : mtime_inc[63:32],
    mtime_we  ? merge_bytes(mtime_q[31:0], timer_wdata_i, timer_be_i)  : mtime_inc[31:0]
  };

  assign mtimecmp_d = {
    mtimecmph_we ? merge_bytes(mtimecmp_q[63:32], timer_wdata_i, timer_be_i)
                 : mtimecmp_q[63:32],
    mtimecmp_we  ? merge_bytes(mtimecmp_q[31:0], timer_wdata_i, timer_be_i)
                 : mtimecmp_q[31:0]
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtimecmp_q <= '0;
    end else if (cmp_wr) begin
      mtimecmp_q <= mtimecmp_d;
    end
  end

  // Compare is armed once mtimecmp has been programmed after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q <= 1'b0;
    end else if (cmp_wr) begin
      armed_q <= 1'b1;
    end
  end

  // Sticky until the next mtimecmp write
  assign intr_d = ((armed_q & (mtime_q >= mtimecmp_q)) | intr_q) & ~cmp_wr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_q <= 1'b0;
    end else begin
      intr_q <= intr_d;
    end
  end

  assign timer_intr_o = intr_q;

  // Read mux, unknown offsets answer with an error
  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    unique case (reg_off)
      `DEV_ADDR_BITS'(`MTIME_LOW):     rdata_d = mtime_q[31:0];
      `DEV_ADDR_BITS'(`MTIME_HIGH):    rdata_d = mtime_q[63:32];
      `DEV_ADDR_BITS'(`MTIMECMP_LOW):  rdata_d = mtimecmp_q[31:0];
      `DEV_ADDR_BITS'(`MTIMECMP_HIGH): rdata_d = mtimecmp_q[63:32];
      default:                         err_d   = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (timer_req_i) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  // Every request is answered in the next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= timer_req_i;
    end
  end

  assign timer_rvalid_o = rvalid_q;
  assign timer_rdata_o  = rdata_q;
  assign timer_err_o    = err_q;

endmodule

// ==== rtl/bus_decoder.sv ====
// Address decoder for the peripheral bus
// Picks RAM or timer by region and muxes the response one cycle later,
// answers unmapped regions with an error

`timescale 1ns/1ps

`include "periph_defs.svh"

module bus_decoder import periph_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Request side
  input  logic      bus_req_i,
  input  bus_addr_t bus_addr_i,
  // Device responses
  input  bus_data_t ram_rdata_i,
  input  logic      timer_rvalid_i,
  input  bus_data_t timer_rdata_i,
  input  logic      timer_err_i,
  // Device requests
  output logic      ram_req_o,
  output logic      timer_req_o,
  // Response to the master
  output logic      bus_rvalid_o,
  output bus_data_t bus_rdata_o,
  output logic      bus_err_o
);

  localparam int unsigned RegionW = `BUS_AW - `DEV_ADDR_BITS;

  logic [RegionW-1:0] region;
  dev_sel_e           sel_d;
  dev_sel_e           sel_q;
  logic               rvalid_q;

  assign region = bus_addr_i[`BUS_AW-1:`DEV_ADDR_BITS];

  // Region match, at most one target per request
  always_comb begin
    if (!bus_req_i) begin
      sel_d = DEV_NONE;
    end else if (region == RegionW'(`RAM_BASE)) begin
      sel_d = DEV_RAM;
    end else if (region == RegionW'(`TIMER_BASE)) begin
      sel_d = DEV_TIMER;
    end else begin
      sel_d = DEV_NONE;
    end
  end

  assign ram_req_o   = (sel_d == DEV_RAM);
  assign timer_req_o = (sel_d == DEV_TIMER);

  // Remember who owns the response in the next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q    <= DEV_NONE;
      rvalid_q <= 1'b0;
    end else begin
      sel_q    <= sel_d;
      rvalid_q <= bus_req_i;
    end
  end

  // Response mux
  always_comb begin
    bus_rvalid_o = rvalid_q;
    bus_rdata_o  = '0;
    bus_err_o    = 1'b0;
    unique case (sel_q)
      DEV_RAM: begin
        // RAM has no valid of its own
        bus_rdata_o = ram_rdata_i;
      end
      DEV_TIMER: begin
        bus_rvalid_o = timer_rvalid_i;
        bus_rdata_o  = timer_rdata_i;
        bus_err_o    = timer_err_i;
      end
      default: begin
        // Decode error for unmapped regions
        bus_err_o = 1'b1;
      end
    endcase
  end

endmodule

// ==== rtl/periph_pkg.sv ====
// Shared types of the peripheral subsystem
// Bus vectors, the 64-bit timer value and the device select enum

package periph_pkg;

  `include "periph_defs.svh"

  // Bus address
  typedef logic [`BUS_AW-1:0] bus_addr_t;

  // Bus data word
  typedef logic [`BUS_DW-1:0] bus_data_t;

  // One enable per byte lane
  typedef logic [`BUS_DW/8-1:0] bus_be_t;

  // mtime and mtimecmp are always 64 bits
  typedef logic [63:0] timer_cnt_t;

  // Target of a bus request
  typedef enum logic [1:0] {
    DEV_RAM,
    DEV_TIMER,
    DEV_NONE
  } dev_sel_e;

endpackage

// ==== include/periph_defs.svh ====
// Bus widths, address map, RAM depth and timer register offsets
// for the peripheral subsystem

`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// Bus widths
`define BUS_AW 32
`define BUS_DW 32

// Low address bits inside one device region (1 kB each)
`define DEV_ADDR_BITS 10

// Region numbers, taken from the address bits above DEV_ADDR_BITS
`define RAM_BASE   0
`define TIMER_BASE 1

// RAM depth in words, fills one region
`define RAM_WORDS 256

// Timer register byte offsets
`define MTIME_LOW     0
`define MTIME_HIGH    4
`define MTIMECMP_LOW  8
`define MTIMECMP_HIGH 12

`endif
